// ==== src.f ====
+incdir+common
common/lsu_pkg.sv
lsu/lsu_mem.sv
source/data_ram.sv
source/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data memory path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/lsu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
  exit 0
fi
exit 1

// ==== dv/lsu_tb.sv ====
// Data memory path testbench
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

  import lsu_pkg::*;

  logic        clock;
  logic        reset;
  logic        req_valid;
  logic [31:0] req_addr;
  mem_op_t     req_op;
  logic [31:0] req_data;
  logic [31:0] exp_data;
  logic        ack_valid;
  logic [31:0] ack_data;
  int          error_count;
  int          ack_count;
  int          local_errors;
  int          cycles = 0;
  int          cycle_limit;

  // Stimulus table
  // Expected value is used by loads only
  mem_op_t     tab_op[$];
  logic [31:0] tab_addr[$];
  logic [31:0] tab_data[$];
  logic [31:0] tab_exp[$];

  lsu_top lsu_top_i (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_op    (req_op),
    .req_data  (req_data),
    .ack_valid (ack_valid),
    .ack_data  (ack_data)
  );

  lsu_checker lsu_checker_i (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_op      (req_op),
    .req_data    (req_data),
    .exp_data    (exp_data),
    .ack_valid   (ack_valid),
    .ack_data    (ack_data),
    .error_count (error_count),
    .ack_count   (ack_count)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic add_entry(mem_op_t op, logic [31:0] addr, logic [31:0] data,
                           logic [31:0] exp);
    tab_op.push_back(op);
    tab_addr.push_back(addr);
    tab_data.push_back(data);
    tab_exp.push_back(exp);
  endtask

  task automatic build_table();
    logic [31:0] addr;
    logic [31:0] data;
    // Random words in RAM words 64 to 191
    for (int i = 0; i < 8; i++) begin
      addr = ($urandom % 128 + 64) << 2;
      data = $urandom;
      add_entry(OP_SW, addr, data, 32'h0);
      add_entry(OP_LW, addr, 32'h0, data);
    end
    // Byte lanes with junk in the upper data bits
    add_entry(OP_SW, 32'h40, 32'hA5A5A5A5, 32'h0);
    add_entry(OP_SB, 32'h40, 32'hFFFFFF11, 32'h0);
    add_entry(OP_LW, 32'h40, 32'h0, 32'hA5A5A511);
    add_entry(OP_SB, 32'h42, 32'h00000033, 32'h0);
    add_entry(OP_LW, 32'h40, 32'h0, 32'hA533A511);
    add_entry(OP_SB, 32'h41, 32'h12345622, 32'h0);
    add_entry(OP_SB, 32'h43, 32'h00000044, 32'h0);
    add_entry(OP_LW, 32'h40, 32'h0, 32'h44332211);
    // Every byte has bit 7 set
    add_entry(OP_SW, 32'h50, 32'h8090A0F0, 32'h0);
    add_entry(OP_LB, 32'h50, 32'h0, 32'hFFFFFFF0);
    add_entry(OP_LBU, 32'h50, 32'h0, 32'h000000F0);
    add_entry(OP_LB, 32'h51, 32'h0, 32'hFFFFFFA0);
    add_entry(OP_LBU, 32'h51, 32'h0, 32'h000000A0);
    add_entry(OP_LB, 32'h52, 32'h0, 32'hFFFFFF90);
    add_entry(OP_LBU, 32'h52, 32'h0, 32'h00000090);
    add_entry(OP_LB, 32'h53, 32'h0, 32'hFFFFFF80);
    add_entry(OP_LBU, 32'h53, 32'h0, 32'h00000080);
    // Halfwords of both signs
    add_entry(OP_SH, 32'h60, 32'h12347FFE, 32'h0);
    add_entry(OP_SH, 32'h62, 32'hABCDC003, 32'h0);
    add_entry(OP_LH, 32'h60, 32'h0, 32'h00007FFE);
    add_entry(OP_LHU, 32'h60, 32'h0, 32'h00007FFE);
    add_entry(OP_LH, 32'h62, 32'h0, 32'hFFFFC003);
    add_entry(OP_LHU, 32'h62, 32'h0, 32'h0000C003);
    add_entry(OP_LW, 32'h60, 32'h0, 32'hC0037FFE);
    // Untouched words 192 to 255
    add_entry(OP_LW, 32'h300, 32'h0, 32'h0);
    add_entry(OP_LB, 32'h3FF, 32'h0, 32'h0);
    add_entry(OP_LHU, 32'h3A2, 32'h0, 32'h0);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_addr     = 32'h0;
    req_op       = OP_LB;
    req_data     = 32'h0;
    exp_data     = 32'h0;
    local_errors = 0;
    void'($urandom(32'h2f06));
    build_table();
    cycle_limit = tab_op.size() * (`LSU_RAM_WAIT_STATES + 6) + 100;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < tab_op.size(); i++) begin
      @(posedge clock);
      #1;
      req_valid = 1'b1;
      req_op    = tab_op[i];
      req_addr  = tab_addr[i];
      req_data  = tab_data[i];
      exp_data  = tab_exp[i];
      @(posedge clock);
      while (!ack_valid) @(posedge clock);
      #1;
      req_valid = 1'b0;
    end
    repeat (3) @(posedge clock);
    if (ack_count != tab_op.size()) begin
      $display("Expected %0d acknowledges but saw %0d", tab_op.size(), ack_count);
      local_errors++;
    end
    $display("Errors: %0d from checker, %0d from testbench, %0d requests",
             error_count, local_errors, tab_op.size());
    if (error_count + local_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/lsu_checker.sv ====
// Load/store result checker
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_checker (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  logic [31:0]       req_addr,
  input  lsu_pkg::mem_op_t  req_op,
  input  logic [31:0]       req_data,
  input  logic [31:0]       exp_data,
  input  logic              ack_valid,
  input  logic [31:0]       ack_data,
  output int                error_count,
  output int                ack_count
);

  import lsu_pkg::*;

  localparam int BYTES     = `LSU_RAM_WORDS * 4;
  localparam int ACK_LIMIT = `LSU_RAM_WAIT_STATES + 10;

  // Byte-wide copy of the RAM contents
  logic [7:0]  shadow [BYTES];
  logic        pending;
  mem_op_t     p_op;
  int          p_index;
  logic [31:0] p_data;
  logic [31:0] p_exp;
  int          age;
  logic [31:0] predicted;

  initial begin
    for (int i = 0; i < BYTES; i++) begin
      shadow[i] = 8'h00;
    end
  end

  // Byte k of the store data lands at address + k
  function automatic void write_shadow(mem_op_t op, int index, logic [31:0] data);
    int size;
    size = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    for (int k = 0; k < size; k++) begin
      shadow[index + k] = data[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] predict(mem_op_t op, int a);
    case (op)
      OP_LB:   return {{24{shadow[a][7]}}, shadow[a]};
      OP_LBU:  return {24'h0, shadow[a]};
      OP_LH:   return {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
      OP_LHU:  return {16'h0, shadow[a+1], shadow[a]};
      default: return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
    endcase
  endfunction

  // ====================
  // Request tracking
  // ====================

  always @(posedge clock) begin
    if (reset) begin
      pending     = 1'b0;
      error_count = 0;
      ack_count   = 0;
    end else if (ack_valid) begin
      ack_count++;
      if (!pending) begin
        $display("Acknowledge at %0t arrived with no outstanding request", $time);
        error_count++;
      end else if (is_store(p_op)) begin
        write_shadow(p_op, p_index, p_data);
      end else begin
        predicted = predict(p_op, p_index);
        if (ack_data !== predicted) begin
          $display("[ERROR] ack_data expected %h actual %h (%s at %h)",
                   predicted, ack_data, p_op.name(), p_index);
          error_count++;
        end
        if (ack_data !== p_exp) begin
          $display("[ERROR] ack_data table value %h actual %h (%s at %h)",
                   p_exp, ack_data, p_op.name(), p_index);
          error_count++;
        end
      end
      pending = 1'b0;
    end else if (req_valid && !pending) begin
      pending = 1'b1;
      p_op    = req_op;
      p_index = req_addr % BYTES;
      p_data  = req_data;
      p_exp   = exp_data;
      age     = 0;
    end else if (pending) begin
      age++;
      if (age > ACK_LIMIT) begin
        $display("Request %s at %h was never acknowledged", p_op.name(), p_index);
        error_count++;
        pending = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
// Data memory path top level
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  logic [31:0]       req_addr,
  input  lsu_pkg::mem_op_t  req_op,
  input  logic [31:0]       req_data,
  output logic              ack_valid,
  output logic [31:0]       ack_data
);

  // External bus
  logic        dvalid;
  logic [31:0] daddr;
  logic [31:0] dwdata;
  logic [3:0]  dwstb;
  logic        dwrite;
  logic [31:0] drdata;
  logic        dready;

  lsu_mem lsu_mem_i (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_op    (req_op),
    .req_data  (req_data),
    .ack_valid (ack_valid),
    .ack_data  (ack_data),
    .dvalid    (dvalid),
    .daddr     (daddr),
    .dwdata    (dwdata),
    .dwstb     (dwstb),
    .dwrite    (dwrite),
    .drdata    (drdata),
    .dready    (dready)
  );

  data_ram data_ram_i (
    .clock  (clock),
    .reset  (reset),
    .dvalid (dvalid),
    .daddr  (daddr),
    .dwdata (dwdata),
    .dwstb  (dwstb),
    .dwrite (dwrite),
    .drdata (drdata),
    .dready (dready)
  );

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
// Data RAM with wait states
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module data_ram (
  input  logic        clock,
  input  logic        reset,
  input  logic        dvalid,
  input  logic [31:0] daddr,
  input  logic [31:0] dwdata,
  input  logic [3:0]  dwstb,
  input  logic        dwrite,
  output logic [31:0] drdata,
  output logic        dready
);

  localparam int WORDS      = `LSU_RAM_WORDS;
  localparam int WAIT       = `LSU_RAM_WAIT_STATES;
  localparam int ADDR_BITS  = $clog2(WORDS);
  localparam int COUNT_BITS = $clog2(WAIT + 1) + 1;
  localparam logic [COUNT_BITS-1:0] WAIT_LAST = COUNT_BITS'(WAIT);

  logic [31:0]           mem [WORDS];
  logic [ADDR_BITS-1:0]  word_index;
  logic [COUNT_BITS-1:0] wait_count;
  logic                  fire;

  assign word_index = daddr[ADDR_BITS+1:2];

  // Last wait cycle of a pending access
  assign fire = dvalid && !dready && (wait_count == WAIT_LAST);

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = 32'h0;
    end
  end

  // ====================
  // Wait-state counter
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_count <= '0;
      dready     <= 1'b0;
    end else if (dready) begin
      // Handshake completes this cycle
      dready     <= 1'b0;
      wait_count <= '0;
    end else if (fire) begin
      dready     <= 1'b1;
      wait_count <= '0;
    end else if (dvalid) begin
      wait_count <= wait_count + 1'b1;
    end
  end

  // Storage, written per strobed byte
  always_ff @(posedge clock) begin
    if (fire) begin
      if (dwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (dwstb[b]) begin
            mem[word_index][8*b +: 8] <= dwdata[8*b +: 8];
          end
        end
      end
      drdata <= mem[word_index];
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    dvalid && !dready |=> dvalid)
    else $error("dvalid dropped before dready");

endmodule

`default_nettype wire

// ==== lsu/lsu_mem.sv ====
// Load/store unit
`timescale 1ns/1ps
`default_nettype none

module lsu_mem (
  input  logic              clock,
  input  logic              reset,

  // Internal bus from the core
  input  logic              req_valid,
  input  logic [31:0]       req_addr,
  input  lsu_pkg::mem_op_t  req_op,
  input  logic [31:0]       req_data,
  output logic              ack_valid,
  output logic [31:0]       ack_data,

  // External bus to memory
  output logic              dvalid,
  output logic [31:0]       daddr,
  output logic [31:0]       dwdata,
  output logic [3:0]        dwstb,
  output logic              dwrite,
  input  logic [31:0]       drdata,
  input  logic              dready
);

  import lsu_pkg::*;

  mem_state_t  state;
  mem_op_t     load_op;
  logic [1:0]  load_lane;
  logic        issue;
  logic        done;
  logic [3:0]  store_stb;
  logic [31:0] store_data;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  logic [31:0] load_data;

  // No new request while the previous ack is still on the bus
  assign issue = (state == ST_WAIT_REQ) && req_valid && !ack_valid;
  assign done  = (state == ST_WAIT_RSP) && dready;

  assign load_lane = daddr[1:0];

  // ====================
  // Store formatting
  // ====================

  always_comb begin
    case (req_op)
      OP_SB: begin
        store_stb  = 4'b0001 << req_addr[1:0];
        store_data = {4{req_data[7:0]}};
      end
      OP_SH: begin
        store_stb  = req_addr[1] ? 4'b1100 : 4'b0011;
        store_data = {2{req_data[15:0]}};
      end
      OP_SW: begin
        store_stb  = 4'b1111;
        store_data = req_data;
      end
      default: begin
        store_stb  = 4'b0000;
        store_data = 32'h0;
      end
    endcase
  end

  // ====================
  // Load formatting
  // ====================

  always_comb begin
    lane_byte = drdata[8*load_lane +: 8];
    lane_half = load_lane[1] ? drdata[31:16] : drdata[15:0];
    case (load_op)
      OP_LB:   load_data = {{24{lane_byte[7]}}, lane_byte};
      OP_LBU:  load_data = {24'h0, lane_byte};
      OP_LH:   load_data = {{16{lane_half[15]}}, lane_half};
      OP_LHU:  load_data = {16'h0, lane_half};
      default: load_data = drdata;
    endcase
  end

  // ====================
  // Control FSM
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_WAIT_REQ;
      ack_valid <= 1'b0;
      dvalid    <= 1'b0;
      dwrite    <= 1'b0;
      dwstb     <= 4'b0000;
    end else begin
      ack_valid <= 1'b0;
      case (state)
        ST_WAIT_REQ: begin
          if (issue) begin
            dvalid <= 1'b1;
            dwrite <= is_store(req_op);
            dwstb  <= store_stb;
            state  <= ST_WAIT_RSP;
          end
        end
        ST_WAIT_RSP: begin
          if (dready) begin
            ack_valid <= 1'b1;
            dvalid    <= 1'b0;
            dwrite    <= 1'b0;
            dwstb     <= 4'b0000;
            state     <= ST_WAIT_REQ;
          end
        end
        default: state <= ST_WAIT_REQ;
      endcase
    end
  end

  // Address, write data and load info held for the whole transfer
  always_ff @(posedge clock) begin
    if (issue) begin
      daddr   <= req_addr;
      dwdata  <= store_data;
      load_op <= req_op;
    end
    // Stores keep the last ack_data
    if (done && !dwrite) begin
      ack_data <= load_data;
    end
  end

  // ====================
  // Assertions
  // ====================

  // Requester must keep accesses naturally aligned
  assert property (@(posedge clock) disable iff (reset)
    req_valid |-> op_aligned(req_op, req_addr[1:0]))
    else $error("misaligned request: op %0d addr %h", req_op, req_addr);

  assert property (@(posedge clock) disable iff (reset)
    (dwstb != 4'b0000) == dwrite)
    else $error("dwstb %b does not match dwrite %b", dwstb, dwrite);

  // One acknowledge per request, even when the request is held
  assert property (@(posedge clock) disable iff (reset)
    ack_valid |=> !ack_valid)
    else $error("ack_valid high for two cycles");

endmodule

`default_nettype wire

// ==== common/lsu_pkg.sv ====
// Load/store unit package
`default_nettype none

package lsu_pkg;

  // ====================
  // Memory operations
  // ====================

  // Bit 3 marks a store, bit 2 an unsigned load
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_SB  = 4'd8,
    OP_SH  = 4'd9,
    OP_SW  = 4'd10
  } mem_op_t;

  // Request handling states of the load/store unit
  typedef enum logic {
    ST_WAIT_REQ,
    ST_WAIT_RSP
  } mem_state_t;

  function automatic logic is_store(mem_op_t op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

  // Natural alignment for the access size of an operation
  function automatic logic op_aligned(mem_op_t op, logic [1:0] offset);
    case (op)
      OP_LH, OP_LHU, OP_SH: return offset[0] == 1'b0;
      OP_LW, OP_SW:         return offset == 2'b00;
      default:              return 1'b1;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== common/lsu_config.svh ====
// Data memory configuration
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ====================
// Data RAM
// ====================

// Depth in 32-bit words, a power of two
`define LSU_RAM_WORDS 256

// Idle cycles before dready
// Zero gives a one-cycle registered response
`define LSU_RAM_WAIT_STATES 2

`endif
